// ==== include/upsample_defs.svh ====
// Upsampler build constants.
// Pixel width, the repeat factor used in both directions and the
// longest widened row that the row buffer can hold.

`ifndef UPSAMPLE_DEFS_SVH
`define UPSAMPLE_DEFS_SVH

// bits in one pixel value.
`define UPS_DATA_WIDTH 16

// copies per pixel horizontally and per row vertically.
`define UPS_REPEAT 2

// longest output row, in pixels, that row_repeat can store.
`define UPS_ROW_DEPTH 16

`endif

// ==== rtl/upsample_pkg.sv ====
// Upsampler shared types.
// The stream beat and the phase encoding of the row repeat stage.

`include "upsample_defs.svh"

package upsample_pkg;

    // One transfer on any upsampler stream link.
    typedef struct packed {
        logic [`UPS_DATA_WIDTH-1:0] data;  // pixel value.
        logic                       last;  // set on the final pixel of a row.
    } pixel_beat_t;

    // Phases of the row repeat stage.
    typedef enum logic [0:0] {
        row_fill,    // new rows are accepted, stored and forwarded.
        row_replay   // the stored row is sent again from the buffer.
    } row_state_e;

endpackage

// ==== rtl/register_slice.sv ====
// One-entry valid/ready buffer for pixel beats.
// The held beat can be replaced in the cycle it drains, so an unstalled
// stream passes at one beat per cycle with one cycle of latency.

`timescale 1ns/10ps

module register_slice (
    input  logic                      clk,
    input  logic                      rst,
    input  upsample_pkg::pixel_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    output upsample_pkg::pixel_beat_t out_beat,
    output logic                      out_valid,
    input  logic                      out_ready
);

    upsample_pkg::pixel_beat_t beat_q;
    logic                      valid_q;
    logic                      load;

    assign in_ready = !valid_q || out_ready;  // empty, or the held beat leaves now.
    assign load     = in_valid && in_ready;

    // Valid follows the input whenever the slot is free to change.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;  // drains to empty when nothing new arrives.
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            beat_q <= in_beat;
        end
    end

    assign out_beat  = beat_q;
    assign out_valid = valid_q;

    // A beat that the consumer refuses must still be there, unchanged, next cycle.
    stall_holds_beat: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    ) else $error("register_slice changed or dropped a stalled beat.");

endmodule

// ==== rtl/element_repeat.sv ====
// Horizontal nearest-neighbour stage.
// Sends every accepted pixel REPEAT times in a row through an output
// register slice; only the final copy of a row-ending pixel keeps last.

`timescale 1ns/10ps

`include "upsample_defs.svh"

module element_repeat #(
    parameter int REPEAT = `UPS_REPEAT
) (
    input  logic                      clk,
    input  logic                      rst,
    input  upsample_pkg::pixel_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    output upsample_pkg::pixel_beat_t out_beat,
    output logic                      out_valid,
    input  logic                      out_ready
);

    generate
        if (REPEAT == 1) begin : gen_pass

            assign out_beat  = in_beat;   // one copy means nothing to widen.
            assign out_valid = in_valid;
            assign in_ready  = out_ready;

        end else begin : gen_repeat

            localparam int CNT_W = $clog2(REPEAT);

            upsample_pkg::pixel_beat_t hold_beat;
            logic                      hold_valid;
            logic [CNT_W-1:0]          count;      // copies of hold_beat already sent.
            upsample_pkg::pixel_beat_t copy_beat;
            logic                      copy_ready;
            logic                      last_copy;
            logic                      take;

            assign last_copy = count == CNT_W'(REPEAT - 1);
            assign take      = hold_valid && copy_ready;

            // The next pixel may enter as the final copy of this one leaves.
            assign in_ready = !hold_valid || (copy_ready && last_copy);

            always_comb begin
                copy_beat.data = hold_beat.data;
                copy_beat.last = hold_beat.last && last_copy;  // row end on final copy only.
            end

            always_ff @(posedge clk) begin
                if (in_valid && in_ready) begin
                    hold_beat <= in_beat;
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    hold_valid <= 1'b0;
                    count      <= '0;
                end else begin
                    if (in_valid && in_ready) begin
                        hold_valid <= 1'b1;
                    end else if (take && last_copy) begin
                        hold_valid <= 1'b0;  // all copies out and no new pixel waiting.
                    end
                    if (take) begin
                        count <= last_copy ? '0 : count + 1'b1;
                    end
                end
            end

            register_slice out_slice (
                .clk      (clk),
                .rst      (rst),
                .in_beat  (copy_beat),
                .in_valid (hold_valid),
                .in_ready (copy_ready),
                .out_beat (out_beat),
                .out_valid(out_valid),
                .out_ready(out_ready)
            );

            // The copy counter wraps at REPEAT-1 and must never reach REPEAT.
            count_in_range: assert property (
                @(posedge clk) disable iff (rst)
                int'(count) < REPEAT
            ) else $error("element_repeat copy counter reached REPEAT.");

        end
    endgenerate

endmodule

// ==== rtl/row_repeat.sv ====
// Vertical nearest-neighbour stage.
// Forwards each incoming row while writing it to a row buffer, then
// replays the stored row REPEAT-1 more times before taking the next one.
// The stored length marks last on every replayed copy.

`timescale 1ns/10ps

`include "upsample_defs.svh"

module row_repeat #(
    parameter int REPEAT = `UPS_REPEAT
) (
    input  logic                      clk,
    input  logic                      rst,
    input  upsample_pkg::pixel_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    output upsample_pkg::pixel_beat_t out_beat,
    output logic                      out_valid,
    input  logic                      out_ready
);

    localparam int DEPTH = `UPS_ROW_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int LEN_W = $clog2(DEPTH + 1);
    localparam int RC_W  = (REPEAT > 2) ? $clog2(REPEAT - 1) : 1;

    logic [`UPS_DATA_WIDTH-1:0] row_mem [DEPTH];

    upsample_pkg::row_state_e  state;
    logic [LEN_W-1:0]          wr_idx;    // next free slot while filling.
    logic [IDX_W-1:0]          rd_idx;    // next slot to replay.
    logic [LEN_W-1:0]          row_len;   // pixels in the stored row.
    logic [RC_W-1:0]           rep_cnt;   // replays already finished.
    upsample_pkg::pixel_beat_t beat_q;
    logic                      valid_q;
    logic                      slot_free;
    logic                      take_in;
    logic                      emit_replay;
    logic                      rd_last;
    logic                      last_pass;

    assign slot_free   = !valid_q || out_ready;  // output register can load this cycle.
    assign in_ready    = (state == upsample_pkg::row_fill) && slot_free;
    assign take_in     = in_valid && in_ready;
    assign emit_replay = (state == upsample_pkg::row_replay) && slot_free;
    assign rd_last     = (LEN_W'(rd_idx) + LEN_W'(1)) == row_len;
    assign last_pass   = rep_cnt == RC_W'(REPEAT - 2);

    always_ff @(posedge clk) begin
        if (take_in) begin
            row_mem[wr_idx[IDX_W-1:0]] <= in_beat.data;
        end
    end

    // Output register, loaded from the input in fill and from the buffer in replay.
    always_ff @(posedge clk) begin
        if (take_in) begin
            beat_q <= in_beat;
        end else if (emit_replay) begin
            beat_q.data <= row_mem[rd_idx];
            beat_q.last <= rd_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= upsample_pkg::row_fill;
            valid_q <= 1'b0;
            wr_idx  <= '0;
            rd_idx  <= '0;
            row_len <= '0;
            rep_cnt <= '0;
        end else begin
            if (slot_free) begin
                valid_q <= take_in || emit_replay;
            end

            if (take_in) begin
                if (in_beat.last) begin
                    row_len <= wr_idx + 1'b1;
                    wr_idx  <= '0;
                    if (REPEAT > 1) begin
                        state <= upsample_pkg::row_replay;  // row stored, start the copies.
                    end
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end

            if (emit_replay) begin
                if (rd_last) begin
                    rd_idx <= '0;
                    if (last_pass) begin
                        rep_cnt <= '0;
                        state   <= upsample_pkg::row_fill;  // all copies sent.
                    end else begin
                        rep_cnt <= rep_cnt + 1'b1;
                    end
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

    assign out_beat  = beat_q;
    assign out_valid = valid_q;

    // A widened row longer than the buffer would overwrite the stored pixels.
    row_fits_buffer: assert property (
        @(posedge clk) disable iff (rst)
        take_in |-> wr_idx < LEN_W'(DEPTH)
    ) else $error("row_repeat row is longer than the row buffer.");

    // Upstream must be stalled for the whole replay.
    no_input_in_replay: assert property (
        @(posedge clk) disable iff (rst)
        state == upsample_pkg::row_replay |-> !in_ready
    ) else $error("row_repeat accepted input during replay.");

endmodule

// ==== rtl/upsample_2d.sv ====
// Two-dimensional nearest-neighbour upsampler.
// Widens each pixel with element_repeat, then repeats each widened
// row with row_repeat, both by the same factor.

`timescale 1ns/10ps

`include "upsample_defs.svh"

module upsample_2d (
    input  logic                      clk,
    input  logic                      rst,
    input  upsample_pkg::pixel_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    output upsample_pkg::pixel_beat_t out_beat,
    output logic                      out_valid,
    input  logic                      out_ready
);

    // widened rows between the two stages.
    upsample_pkg::pixel_beat_t wide_beat;
    logic                      wide_valid;
    logic                      wide_ready;

    element_repeat #(
        .REPEAT(`UPS_REPEAT)
    ) horizontal (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (in_beat),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_beat (wide_beat),
        .out_valid(wide_valid),
        .out_ready(wide_ready)
    );

    row_repeat #(
        .REPEAT(`UPS_REPEAT)
    ) vertical (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (wide_beat),
        .in_valid (wide_valid),
        .in_ready (wide_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// ==== tests/upsample_2d_tb.sv ====
// Testbench for the two-dimensional upsampler.
// Streams the input rows of the golden file with random gaps, applies
// random back-pressure and compares every output beat and its last flag.

`timescale 1ns/10ps

`include "upsample_defs.svh"

module upsample_2d_tb;

    logic                      clk;
    logic                      rst;
    upsample_pkg::pixel_beat_t in_beat;
    logic                      in_valid;
    logic                      in_ready;
    upsample_pkg::pixel_beat_t out_beat;
    logic                      out_valid;
    logic                      out_ready;

    upsample_pkg::pixel_beat_t in_q[$];   // input beats in send order.
    upsample_pkg::pixel_beat_t exp_q[$];  // expected output beats.

    int value_errors;
    int stream_errors;
    int rx_count;
    int cycles;
    int cycle_limit;

    upsample_2d dut (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (in_beat),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Guards against a stalled pipeline.
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d output beats received",
                     cycles, rx_count, exp_q.size());
            $display("errors: %0d mismatches, %0d stream errors", value_errors, stream_errors);
            $display("Test FAILED");
            $finish;
        end
    end

    // Reads tagged rows; i rows go to the input queue, e rows to the expected queue.
    task automatic load_golden();
        int                         fd;
        int                         n;
        int                         len;
        int                         k;
        logic [7:0]                 tag;
        logic [`UPS_DATA_WIDTH-1:0] value;
        reg [8*256-1:0]             skip_line;
        upsample_pkg::pixel_beat_t  beat;
        bit                         done;
        fd = $fopen("tests/upsample_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file tests/upsample_golden.txt");
            $display("Test FAILED");
            $finish;
        end
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                n = $fgets(skip_line, fd);  // comment line.
            end else begin
                n = $fscanf(fd, "%d", len);
                for (k = 0; k < len; k++) begin
                    n = $fscanf(fd, "%h", value);
                    beat.data = value;
                    beat.last = (k == len - 1);  // row end on the final pixel.
                    if (tag == "i") begin
                        in_q.push_back(beat);
                    end else if (tag == "e") begin
                        exp_q.push_back(beat);
                    end
                end
                assert (tag == "i" || tag == "e") else begin
                    stream_errors++;
                    $display("golden file holds a row with an unknown tag %c", tag);
                end
            end
        end
        $fclose(fd);
    endtask

    // Drives each input beat, with a random idle gap before some of them.
    task automatic send_inputs();
        int i;
        int gaps;
        for (i = 0; i < in_q.size(); i++) begin
            gaps = (($urandom % 4) == 0) ? ($urandom % 3) + 1 : 0;
            if (gaps > 0) begin
                in_valid = 1'b0;
                repeat (gaps) @(posedge clk);
                #1;
            end
            in_beat  = in_q[i];
            in_valid = 1'b1;
            do @(posedge clk); while (!in_ready);
            #1;
        end
        in_valid = 1'b0;
        in_beat  = '0;
    endtask

    task automatic check_beat();
        upsample_pkg::pixel_beat_t exp;
        assert (rx_count < exp_q.size()) else begin
            stream_errors++;
            $display("extra output beat %h at %0t ns after the expected sequence ended",
                     out_beat.data, $time);
        end
        if (rx_count < exp_q.size()) begin
            exp = exp_q[rx_count];
            assert (out_beat.data == exp.data) else begin
                value_errors++;
                $display("mismatch at %0t ns: beat %0d data %h, expected %h",
                         $time, rx_count, out_beat.data, exp.data);
            end
            assert (out_beat.last == exp.last) else begin
                value_errors++;
                $display("mismatch at %0t ns: beat %0d last %b, expected %b",
                         $time, rx_count, out_beat.last, exp.last);
            end
        end
        rx_count++;
    endtask

    // Samples transfers at the edge, then picks the next out_ready at random.
    task automatic watch_outputs();
        forever begin
            @(posedge clk);
            if (out_valid && out_ready) begin
                check_beat();
            end
            #1;
            out_ready = ($urandom % 4) != 0;
        end
    endtask

    initial begin
        void'($urandom(94));
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_beat       = '0;
        out_ready     = 1'b0;
        value_errors  = 0;
        stream_errors = 0;
        rx_count      = 0;
        cycles        = 0;
        cycle_limit   = 200;

        load_golden();
        cycle_limit = 20 * exp_q.size() + 200;
        assert (exp_q.size() == in_q.size() * `UPS_REPEAT * `UPS_REPEAT) else begin
            stream_errors++;
            $display("golden file lists %0d expected beats for %0d input pixels",
                     exp_q.size(), in_q.size());
        end

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // Nothing may come out before the first input beat.
        repeat (5) begin
            @(posedge clk);
            assert (!out_valid) else begin
                stream_errors++;
                $display("out_valid went high at %0t ns before any input was sent", $time);
            end
        end
        #1;

        fork
            send_inputs();
            watch_outputs();
        join_none

        wait (rx_count >= exp_q.size());
        repeat (40) @(posedge clk);  // a late extra beat would show up here.

        assert (rx_count == exp_q.size()) else begin
            stream_errors++;
            $display("received %0d output beats, expected %0d", rx_count, exp_q.size());
        end

        $display("errors: %0d mismatches, %0d stream errors", value_errors, stream_errors);
        if (value_errors == 0 && stream_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/upsample_pkg.sv
rtl/register_slice.sv
rtl/element_repeat.sv
rtl/row_repeat.sv
rtl/upsample_2d.sv
tests/upsample_2d_tb.sv

// ==== tests/upsample_golden.txt ====
# i <n> <pixels> is one input row, e <n> <pixels> is one expected output row.
# counts are decimal and pixels are hex; last falls on the final pixel of each row.
i 2 0011 0022
e 4 0011 0011 0022 0022
e 4 0011 0011 0022 0022
i 3 0a01 0a02 0a03
e 6 0a01 0a01 0a02 0a02 0a03 0a03
e 6 0a01 0a01 0a02 0a02 0a03 0a03
i 4 1234 5678 9abc def0
e 8 1234 1234 5678 5678 9abc 9abc def0 def0
e 8 1234 1234 5678 5678 9abc 9abc def0 def0
i 1 ffff
e 2 ffff ffff
e 2 ffff ffff
i 8 0100 0101 0102 0103 0104 0105 0106 0107
e 16 0100 0100 0101 0101 0102 0102 0103 0103 0104 0104 0105 0105 0106 0106 0107 0107
e 16 0100 0100 0101 0101 0102 0102 0103 0103 0104 0104 0105 0105 0106 0106 0107 0107
i 2 7e7e 0001
e 4 7e7e 7e7e 0001 0001
e 4 7e7e 7e7e 0001 0001
i 3 c0de 0000 8001
e 6 c0de c0de 0000 0000 8001 8001
e 6 c0de c0de 0000 0000 8001 8001
